// ==== logic/audio_pkg.sv ====
package audio_pkg;

    // Default build values, overridden through the top-level parameters
    parameter int SAMPLE_WIDTH = 24;  // Bits per channel sample
    parameter int SLOT_BITS    = 32;  // Bit clocks per channel slot, 64 per frame
    parameter int BCLK_DIV     = 4;   // clk cycles per bit clock half period
    parameter int FIFO_DEPTH   = 16;  // Frames held, power of two

    // One channel sample, two's complement
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // Left word in the upper half, right word in the lower half
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_frame_t;

endpackage : audio_pkg

// ==== logic/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo #(
    parameter int DEPTH = audio_pkg::FIFO_DEPTH
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     push,
    input  audio_pkg::stereo_frame_t wr_frame,
    input  logic                     pop,
    output audio_pkg::stereo_frame_t rd_frame,
    output logic                     empty,
    output logic                     full,
    output logic                     overflow
);
    import audio_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    stereo_frame_t    mem [DEPTH];
    logic [PTR_W:0]   wr_ptr;  // MSB is the wrap bit
    logic [PTR_W:0]   rd_ptr;
    logic             wr_en;

    // Same index and different wrap bits means every entry is in use
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign wr_en    = push && !full;
    assign rd_frame = mem[rd_ptr[PTR_W-1:0]];  // Head frame, combinational

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[PTR_W-1:0]] <= wr_frame;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (push && full) begin
                overflow <= 1'b1;  // Frame dropped, stays set until reset
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // The serializer only pops a frame that is present
    a_no_pop_when_empty : assert property (
        @(posedge clk) disable iff (!resetn)
        pop |-> !empty
    ) else $error("sample_fifo: pop while empty");

    // Pointer distance never goes past the depth
    a_occupancy_range : assert property (
        @(posedge clk) disable iff (!resetn)
        (wr_ptr - rd_ptr) <= (PTR_W + 1)'(DEPTH)
    ) else $error("sample_fifo: occupancy beyond the depth");

endmodule : sample_fifo

// ==== logic/i2s_clock_gen.sv ====
`timescale 1ns/1ps

module i2s_clock_gen #(
    parameter int BCLK_DIV  = audio_pkg::BCLK_DIV,
    parameter int SLOT_BITS = audio_pkg::SLOT_BITS
) (
    input  logic clk,
    input  logic resetn,
    output logic bclk,
    output logic lrclk,
    output logic bclk_fall,
    output logic frame_start
);
    localparam int DIV_W = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;
    localparam int BIT_W = (SLOT_BITS > 1) ? $clog2(SLOT_BITS) : 1;

    logic [DIV_W-1:0] div_cnt;   // clk cycles within the current half period
    logic [BIT_W-1:0] bit_cnt;   // Bit clock falls within the current slot
    logic             half_done;
    logic             slot_done;

    assign half_done = (div_cnt == DIV_W'(BCLK_DIV - 1));
    assign slot_done = (bit_cnt == BIT_W'(SLOT_BITS - 1));

    // Strobes are registered with the clocks, so they line up with the output edges
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            div_cnt     <= '0;
            bit_cnt     <= '0;
            bclk        <= 1'b0;
            lrclk       <= 1'b1;  // First word clock fall one slot after reset
            bclk_fall   <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            bclk_fall   <= 1'b0;
            frame_start <= 1'b0;
            if (half_done) begin
                div_cnt <= '0;
                bclk    <= ~bclk;
                if (bclk) begin  // High now, so this is a falling edge
                    bclk_fall <= 1'b1;
                    if (slot_done) begin
                        bit_cnt     <= '0;
                        lrclk       <= ~lrclk;
                        frame_start <= lrclk;  // High to low starts the left slot
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    a_frame_on_fall : assert property (
        @(posedge clk) disable iff (!resetn)
        frame_start |-> bclk_fall && !lrclk
    ) else $error("i2s_clock_gen: frame_start away from a bclk fall");

endmodule : i2s_clock_gen

// ==== logic/i2s_serializer.sv ====
`timescale 1ns/1ps

module i2s_serializer #(
    parameter int SAMPLE_WIDTH = audio_pkg::SAMPLE_WIDTH,
    parameter int SLOT_BITS    = audio_pkg::SLOT_BITS
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     bclk_fall,
    input  logic                     frame_start,
    input  logic                     lrclk,
    input  audio_pkg::stereo_frame_t rd_frame,
    input  logic                     empty,
    output logic                     pop,
    output logic                     sdata,
    output logic                     underflow
);
    import audio_pkg::*;

    localparam int CNT_W = $clog2(SLOT_BITS + 1);

    stereo_frame_t           cur_frame;   // Frame being sent in this word clock period
    logic [SAMPLE_WIDTH-1:0] slot_word;
    logic [SAMPLE_WIDTH-1:0] shift_reg;
    logic [CNT_W-1:0]        bit_cnt;     // Index of the bit going out on this fall
    logic                    lr_prev;     // Word clock level at the previous fall
    logic                    slot_edge;

    // Take the head frame at frame start, only if one is there
    assign pop = frame_start && !empty;

    assign slot_edge = (lrclk != lr_prev);
    assign slot_word = lrclk ? cur_frame.right : cur_frame.left;

    // A starved frame period sends silence
    always_ff @(posedge clk) begin
        if (frame_start) begin
            cur_frame <= empty ? '0 : rd_frame;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            shift_reg <= '0;
            bit_cnt   <= CNT_W'(SLOT_BITS - 1);  // Parked, so only zeros go out
            lr_prev   <= 1'b1;
            sdata     <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (frame_start && empty) begin
                underflow <= 1'b1;
            end

            if (bclk_fall) begin
                lr_prev <= lrclk;
                if (!slot_edge && bit_cnt == '0) begin
                    // One bit after the word clock edge, MSB straight from the frame
                    sdata     <= slot_word[SAMPLE_WIDTH-1];
                    shift_reg <= {slot_word[SAMPLE_WIDTH-2:0], 1'b0};
                    bit_cnt   <= CNT_W'(1);
                end else begin
                    // Past the sample width the slot is padded with zeros
                    sdata     <= (bit_cnt < SAMPLE_WIDTH) && shift_reg[SAMPLE_WIDTH-1];
                    shift_reg <= {shift_reg[SAMPLE_WIDTH-2:0], 1'b0};
                    if (slot_edge) begin
                        bit_cnt <= '0;  // Last bit of the old slot goes out on the edge
                    end else if (bit_cnt != CNT_W'(SLOT_BITS - 1)) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // Word clock edges must arrive every SLOT_BITS falls
    a_slot_length : assert property (
        @(posedge clk) disable iff (!resetn)
        bclk_fall && slot_edge |-> bit_cnt == CNT_W'(SLOT_BITS - 1)
    ) else $error("i2s_serializer: word clock edge before the end of the slot");

endmodule : i2s_serializer

// ==== logic/audio_dac_top.sv ====
`timescale 1ns/1ps

module audio_dac_top #(
    parameter int SAMPLE_WIDTH = audio_pkg::SAMPLE_WIDTH,
    parameter int SLOT_BITS    = audio_pkg::SLOT_BITS,
    parameter int BCLK_DIV     = audio_pkg::BCLK_DIV,
    parameter int FIFO_DEPTH   = audio_pkg::FIFO_DEPTH
) (
    input  logic               clk,
    input  logic               resetn,

    // Sample source
    input  audio_pkg::sample_t audio_left,
    input  audio_pkg::sample_t audio_right,
    input  logic               audio_valid,
    output logic               audio_ready,

    // I2S to the DAC
    output logic               i2s_bclk,
    output logic               i2s_lrclk,
    output logic               i2s_sdata,

    // Sticky error flags
    output logic               fifo_overflow,
    output logic               fifo_underflow
);
    import audio_pkg::*;

    stereo_frame_t wr_frame;
    stereo_frame_t rd_frame;
    logic          fifo_empty;
    logic          fifo_full;
    logic          fifo_pop;
    logic          bclk_fall;
    logic          frame_start;

    // The frame type is fixed by the package, so the sample width has to agree
    if (SAMPLE_WIDTH != $bits(sample_t)) begin : g_width_check
        $error("audio_dac_top: SAMPLE_WIDTH differs from audio_pkg::sample_t");
    end

    assign wr_frame.left  = audio_left;
    assign wr_frame.right = audio_right;
    assign audio_ready    = !fifo_full;  // High after reset, FIFO starts empty

    // Push while full is dropped inside the FIFO and counted as overflow
    sample_fifo #(
        .DEPTH     (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .resetn    (resetn),
        .push      (audio_valid),
        .wr_frame  (wr_frame),
        .pop       (fifo_pop),
        .rd_frame  (rd_frame),
        .empty     (fifo_empty),
        .full      (fifo_full),
        .overflow  (fifo_overflow)
    );

    i2s_clock_gen #(
        .BCLK_DIV    (BCLK_DIV),
        .SLOT_BITS   (SLOT_BITS)
    ) u_clk_gen (
        .clk         (clk),
        .resetn      (resetn),
        .bclk        (i2s_bclk),
        .lrclk       (i2s_lrclk),
        .bclk_fall   (bclk_fall),
        .frame_start (frame_start)
    );

    i2s_serializer #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .SLOT_BITS    (SLOT_BITS)
    ) u_serializer (
        .clk          (clk),
        .resetn       (resetn),
        .bclk_fall    (bclk_fall),
        .frame_start  (frame_start),
        .lrclk        (i2s_lrclk),
        .rd_frame     (rd_frame),
        .empty        (fifo_empty),
        .pop          (fifo_pop),
        .sdata        (i2s_sdata),
        .underflow    (fifo_underflow)
    );

endmodule : audio_dac_top

// ==== dv/audio_checker.sv ====
`timescale 1ns/1ps

module audio_checker #(
    parameter int SAMPLE_WIDTH = audio_pkg::SAMPLE_WIDTH,
    parameter int SLOT_BITS    = audio_pkg::SLOT_BITS,
    parameter int BCLK_DIV     = audio_pkg::BCLK_DIV,
    parameter int FIFO_DEPTH   = audio_pkg::FIFO_DEPTH
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic [SAMPLE_WIDTH-1:0] audio_left,
    input  logic [SAMPLE_WIDTH-1:0] audio_right,
    input  logic                    audio_valid,
    input  logic                    audio_ready,
    input  logic                    i2s_bclk,
    input  logic                    i2s_lrclk,
    input  logic                    i2s_sdata,
    input  logic                    fifo_overflow,
    input  logic                    fifo_underflow,
    output int                      pending
);
    localparam int FW      = 2 * SAMPLE_WIDTH;
    localparam int T_RESET = 0;
    localparam int T_CLOCK = 1;
    localparam int T_DATA  = 2;
    localparam int T_UNDER = 3;
    localparam int T_OVER  = 4;
    localparam int T_DRAIN = 5;

    logic [FW-1:0]           exp_q [$];      // Accepted frames not yet popped
    logic [FW-1:0]           inflight;       // Frame going out in this word clock period
    logic                    inflight_valid;
    logic                    starved_now;    // Current period was started on an empty FIFO
    logic                    have_frame;
    logic [SAMPLE_WIDTH-1:0] left_word;
    logic [SAMPLE_WIDTH-1:0] right_word;
    logic                    bclk_q;
    logic                    lrclk_q;
    logic                    reset_checked;
    logic                    have_rise;
    logic                    exp_ovf;
    logic                    exp_unf;
    int                      test_err [6];
    int                      cyc;
    int                      last_rise;
    int                      fall_cnt;       // bclk falls since the last lrclk edge
    int                      rise_idx;       // bclk rises since the last lrclk edge
    int                      frames_ok;
    int                      dropped;
    int                      starves;

    task automatic mismatch(input int test, input string name,
                            input logic [FW-1:0] exp_v, input logic [FW-1:0] act_v);
        $display("ERR t=%0t signal=%s expected=%h actual=%h", $time, name, exp_v, act_v);
        test_err[test]++;
    endtask

    always @(posedge clk) begin : watch
        logic rise;
        logic fall;
        if (!resetn) begin
            exp_q.delete();
            inflight       = '0;
            inflight_valid = 1'b0;
            starved_now    = 1'b0;
            have_frame     = 1'b0;
            left_word      = '0;
            right_word     = '0;
            bclk_q         = 1'b0;
            lrclk_q        = 1'b1;
            reset_checked  = 1'b0;
            have_rise      = 1'b0;
            exp_ovf        = 1'b0;
            exp_unf        = 1'b0;
            cyc            = 0;
            fall_cnt       = 0;
            rise_idx       = 0;
            pending        = 0;
        end else begin
            rise = !bclk_q && i2s_bclk;
            fall = bclk_q && !i2s_bclk;
            cyc++;

            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (audio_ready !== 1'b1) mismatch(T_RESET, "audio_ready", 1, audio_ready);
                if (i2s_bclk !== 1'b0) mismatch(T_RESET, "i2s_bclk", 0, i2s_bclk);
                if (i2s_lrclk !== 1'b1) mismatch(T_RESET, "i2s_lrclk", 1, i2s_lrclk);
                if (i2s_sdata !== 1'b0) mismatch(T_RESET, "i2s_sdata", 0, i2s_sdata);
                if (fifo_overflow !== 1'b0) mismatch(T_RESET, "fifo_overflow", 0, fifo_overflow);
                if (fifo_underflow !== 1'b0) mismatch(T_RESET, "fifo_underflow", 0, fifo_underflow);
            end

            // Bit clock period and slot length
            if (rise) begin
                if (have_rise && (cyc - last_rise) != 2 * BCLK_DIV)
                    mismatch(T_CLOCK, "i2s_bclk period", 2 * BCLK_DIV, cyc - last_rise);
                have_rise = 1'b1;
                last_rise = cyc;
            end
            if (fall) fall_cnt++;
            if (i2s_lrclk !== lrclk_q) begin
                if (!fall) begin
                    $display("t=%0t i2s_lrclk changed while i2s_bclk was not falling", $time);
                    test_err[T_CLOCK]++;
                end else if (fall_cnt != SLOT_BITS) begin
                    mismatch(T_CLOCK, "i2s_lrclk slot length", SLOT_BITS, fall_cnt);
                end
                fall_cnt = 0;
                rise_idx = 0;
            end

            // Rise 0 of a slot still carries the last pad bit of the slot before
            if (rise) begin
                if (rise_idx >= 1 && rise_idx <= SAMPLE_WIDTH) begin
                    if (i2s_lrclk) right_word = {right_word[SAMPLE_WIDTH-2:0], i2s_sdata};
                    else           left_word  = {left_word[SAMPLE_WIDTH-2:0], i2s_sdata};
                end else if (i2s_sdata !== 1'b0) begin
                    mismatch(T_DATA, "i2s_sdata padding", 0, i2s_sdata);
                end
                rise_idx++;
            end

            if (audio_ready !== (exp_q.size() < FIFO_DEPTH))
                mismatch(T_OVER, "audio_ready", exp_q.size() < FIFO_DEPTH, audio_ready);
            if (fifo_overflow !== exp_ovf) mismatch(T_OVER, "fifo_overflow", exp_ovf, fifo_overflow);
            if (fifo_underflow !== exp_unf)
                mismatch(T_UNDER, "fifo_underflow", exp_unf, fifo_underflow);

            // Word clock fall closes one frame and pops the next
            if (lrclk_q && !i2s_lrclk) begin
                if (have_frame) begin
                    if (starved_now) begin
                        if ({left_word, right_word} !== '0)
                            mismatch(T_UNDER, "i2s_sdata frame", '0, {left_word, right_word});
                    end else if ({left_word, right_word} !== inflight) begin
                        mismatch(T_DATA, "i2s_sdata frame", inflight, {left_word, right_word});
                    end else begin
                        frames_ok++;
                    end
                end
                if (exp_q.size() > 0) begin
                    inflight       = exp_q.pop_front();
                    inflight_valid = 1'b1;
                    starved_now    = 1'b0;
                end else begin
                    inflight_valid = 1'b0;
                    starved_now    = 1'b1;
                    exp_unf        = 1'b1;  // Flag shows on the next cycle
                    starves++;
                end
                have_frame = 1'b1;
                left_word  = '0;
                right_word = '0;
            end

            if (audio_valid && audio_ready) begin
                exp_q.push_back({audio_left, audio_right});
            end else if (audio_valid) begin
                exp_ovf = 1'b1;
                dropped++;
            end

            bclk_q  = i2s_bclk;
            lrclk_q = i2s_lrclk;
            pending = exp_q.size() + (inflight_valid ? 1 : 0);
        end
    end

    task automatic print_summary(output int total);
        string names [6];
        names = '{"reset_state", "clock_shape", "data_order", "underflow", "overflow", "drain"};
        if (starves == 0) begin
            $display("underflow: no frame was ever started on an empty FIFO");
            test_err[T_UNDER]++;
        end
        if (dropped == 0) begin
            $display("overflow: the burst never ran into a full FIFO");
            test_err[T_OVER]++;
        end
        if (pending != 0) begin
            $display("drain: %0d accepted frames never came out", pending);
            test_err[T_DRAIN]++;
        end
        total = 0;
        for (int i = 0; i < 6; i++) begin
            $display("test %-12s %s (%0d errors)", names[i],
                     (test_err[i] == 0) ? "pass" : "fail", test_err[i]);
            total += test_err[i];
        end
        $display("summary: frames=%0d dropped=%0d starved=%0d errors=%0d",
                 frames_ok, dropped, starves, total);
    endtask

endmodule : audio_checker

// ==== dv/tb_audio_dac.sv ====
`timescale 1ns/1ps

module tb_audio_dac;
    import audio_pkg::*;

    localparam int MAX_VEC       = 64;
    localparam int LINE_TIMEOUT  = 2000;   // clk cycles waiting for audio_ready
    localparam int DRAIN_TIMEOUT = 20000;  // clk cycles for the FIFO to empty out
    localparam logic [31:0] RANDOM_GAP = 32'h0000ffff;
    localparam logic [31:0] END_MARK   = 32'hffffffff;

    logic        clk;
    logic        resetn;
    sample_t     audio_left;
    sample_t     audio_right;
    logic        audio_valid;
    logic        audio_ready;
    logic        i2s_bclk;
    logic        i2s_lrclk;
    logic        i2s_sdata;
    logic        fifo_overflow;
    logic        fifo_underflow;

    logic [31:0] vec_mem [4*MAX_VEC];  // Four words per vector line
    int          pending;
    int          errors;
    int          n_vec;
    int          waited;
    logic        timed_out;

    audio_dac_top #(
        .SAMPLE_WIDTH   (SAMPLE_WIDTH),
        .SLOT_BITS      (SLOT_BITS),
        .BCLK_DIV       (BCLK_DIV),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) uut (
        .clk            (clk),
        .resetn         (resetn),
        .audio_left     (audio_left),
        .audio_right    (audio_right),
        .audio_valid    (audio_valid),
        .audio_ready    (audio_ready),
        .i2s_bclk       (i2s_bclk),
        .i2s_lrclk      (i2s_lrclk),
        .i2s_sdata      (i2s_sdata),
        .fifo_overflow  (fifo_overflow),
        .fifo_underflow (fifo_underflow)
    );

    audio_checker #(
        .SAMPLE_WIDTH   (SAMPLE_WIDTH),
        .SLOT_BITS      (SLOT_BITS),
        .BCLK_DIV       (BCLK_DIV),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) u_checker (
        .clk            (clk),
        .resetn         (resetn),
        .audio_left     (audio_left),
        .audio_right    (audio_right),
        .audio_valid    (audio_valid),
        .audio_ready    (audio_ready),
        .i2s_bclk       (i2s_bclk),
        .i2s_lrclk      (i2s_lrclk),
        .i2s_sdata      (i2s_sdata),
        .fifo_overflow  (fifo_overflow),
        .fifo_underflow (fifo_underflow),
        .pending        (pending)
    );

    always #5 clk = ~clk;

    // Inputs move 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input logic [31:0] left_v, input logic [31:0] right_v,
                              input logic [31:0] gap, input logic [31:0] force_v);
        int idle;
        int wait_cnt;
        idle = (gap == RANDOM_GAP) ? $urandom_range(0, 7) : int'(gap);
        audio_valid = 1'b0;
        repeat (idle) next_cycle();
        audio_left  = left_v[SAMPLE_WIDTH-1:0];
        audio_right = right_v[SAMPLE_WIDTH-1:0];
        audio_valid = 1'b1;
        wait_cnt    = 0;
        while (!audio_ready && force_v == 0 && !timed_out) begin  // Forced lines never wait
            next_cycle();
            wait_cnt++;
            if (wait_cnt > LINE_TIMEOUT) begin
                $display("timeout: audio_ready stayed low for %0d cycles", wait_cnt);
                timed_out = 1'b1;
            end
        end
        next_cycle();
        audio_valid = 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        resetn      = 1'b0;
        audio_left  = '0;
        audio_right = '0;
        audio_valid = 1'b0;
        timed_out   = 1'b0;
        errors      = 0;
        void'($urandom(32'h5cb0bfc0));
        $readmemh("dv/audio_vectors.txt", vec_mem);

        repeat (5) @(posedge clk);
        #1 resetn = 1'b1;

        n_vec = 0;
        while (n_vec < MAX_VEC && !timed_out && vec_mem[4*n_vec] !== END_MARK &&
               !$isunknown(vec_mem[4*n_vec])) begin
            send_frame(vec_mem[4*n_vec], vec_mem[4*n_vec+1],
                       vec_mem[4*n_vec+2], vec_mem[4*n_vec+3]);
            n_vec++;
        end

        waited = 0;
        while (pending != 0 && !timed_out) begin
            next_cycle();
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                $display("timeout: %0d frames still queued after %0d cycles", pending, waited);
                timed_out = 1'b1;
            end
        end
        repeat (4 * SLOT_BITS * BCLK_DIV) next_cycle();  // One more frame period of silence

        u_checker.print_summary(errors);
        if (timed_out || errors != 0) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    end

endmodule : tb_audio_dac

// ==== dv/audio_vectors.txt ====
// Columns: left right idle_gap force, all hex; idle_gap ffff picks a random 0..7 cycles
// force 1 keeps valid high while ready is low; a left of ffffffff ends the list
123456 abcdef 0 0
800001 7ffffe 3 0
000001 fffffe ffff 0
5a5a5a a5a5a5 ffff 0
7fffff 800000 1 0
0f0f0f f0f0f0 ffff 0
c00003 3ffffc 2 0
010203 040506 ffff 0
0a0b0c 0d0e0f 1800 0
100001 200001 0 1
100002 200002 0 1
100003 200003 0 1
100004 200004 0 1
100005 200005 0 1
100006 200006 0 1
100007 200007 0 1
100008 200008 0 1
100009 200009 0 1
10000a 20000a 0 1
10000b 20000b 0 1
10000c 20000c 0 1
10000d 20000d 0 1
10000e 20000e 0 1
10000f 20000f 0 1
100010 200010 0 1
100011 200011 0 1
100012 200012 0 1
100013 200013 0 1
100014 200014 0 1
e1e2e3 f1f2f3 ffff 0
000100 001000 ffff 0
fedcba 987654 ffff 0
33cc33 cc33cc ffff 0
ffffffff 0 0 0

// ==== project.f ====
logic/audio_pkg.sv
logic/sample_fifo.sv
logic/i2s_clock_gen.sv
logic/i2s_serializer.sv
logic/audio_dac_top.sv
dv/audio_checker.sv
dv/tb_audio_dac.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the audio DAC testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_audio_dac -o sim_audio_dac &&
./obj_dir/sim_audio_dac | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
echo "run.sh: simulation reported pass" ||
{ echo "run.sh: build or simulation failed"; exit 1; }
